// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct7 classes
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA, ANDN, ORN, XNOR
    localparam logic [6:0] F7_MINMAX = 7'b0000101;
    localparam logic [6:0] F7_ROT    = 7'b0110000;

    // funct3 codes, named after the base ops
    // The Zbb groups reuse the same slots
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001; // also ROL
    localparam logic [2:0] F3_XOR     = 3'b100; // also XNOR, MIN
    localparam logic [2:0] F3_SR      = 3'b101; // SRL/SRA, MINU, ROR
    localparam logic [2:0] F3_OR      = 3'b110; // also ORN, MAX
    localparam logic [2:0] F3_AND     = 3'b111; // also ANDN, MAXU

    // 17 operations plus ALU_NONE need five bits
    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ANDN,
        ALU_ORN,
        ALU_XNOR,
        ALU_MIN,
        ALU_MAX,
        ALU_MINU,
        ALU_MAXU,
        ALU_ROL,
        ALU_ROR
    } alu_op_t;

    // Decode to execute
    typedef struct packed {
        alu_op_t               op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;   // rs2 value or I-immediate
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
    } id_ex_t;

    // Execute to writeback
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  wen;
    } ex_wb_t;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          wr_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [rv_pkg::XLEN-1:0]       wr_data
);
    import rv_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // Free slot, or the held entry leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid; // load, or drain to empty
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic [31:0]                   instr,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          ex_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                          ex_wen,
    input  logic [rv_pkg::XLEN-1:0]       ex_result,
    input  logic                          wb_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                          wb_wen,
    input  logic [rv_pkg::XLEN-1:0]       wb_result,
    output rv_pkg::id_ex_t                id_ex
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    alu_op_t         op;
    logic            use_imm;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign imm_i    = {{(XLEN-12){instr[31]}}, instr[31:20]};

    // Youngest producer wins
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0]       rf_val);
        if (addr == '0)
            return '0;
        else if (ex_valid && ex_wen && ex_rd == addr)
            return ex_result;  // still in the ALU
        else if (wb_valid && wb_wen && wb_rd == addr)
            return wb_result;  // waiting on the output handshake
        else
            return rf_val;
    endfunction

    always_comb begin
        op      = ALU_NONE;
        use_imm = 1'b0;
        if (opcode == OPC_OP_IMM) begin
            use_imm = 1'b1;
            case (funct3)
                F3_ADD_SUB: op = ALU_ADD;
                F3_XOR:     op = ALU_XOR;
                F3_OR:      op = ALU_OR;
                F3_AND:     op = ALU_AND;
                default:    op = ALU_NONE; // shifts and compares not supported
            endcase
        end else if (opcode == OPC_OP) begin
            case ({funct7, funct3})
                {F7_BASE, F3_ADD_SUB}: op = ALU_ADD;
                {F7_BASE, F3_SLL}:     op = ALU_SLL;
                {F7_BASE, F3_XOR}:     op = ALU_XOR;
                {F7_BASE, F3_SR}:      op = ALU_SRL;
                {F7_BASE, F3_OR}:      op = ALU_OR;
                {F7_BASE, F3_AND}:     op = ALU_AND;
                {F7_ALT, F3_ADD_SUB}:  op = ALU_SUB;
                {F7_ALT, F3_SR}:       op = ALU_SRA;
                {F7_ALT, F3_XOR}:      op = ALU_XNOR;
                {F7_ALT, F3_OR}:       op = ALU_ORN;
                {F7_ALT, F3_AND}:      op = ALU_ANDN;
                {F7_MINMAX, F3_XOR}:   op = ALU_MIN;
                {F7_MINMAX, F3_SR}:    op = ALU_MINU;
                {F7_MINMAX, F3_OR}:    op = ALU_MAX;
                {F7_MINMAX, F3_AND}:   op = ALU_MAXU;
                {F7_ROT, F3_SLL}:      op = ALU_ROL;
                {F7_ROT, F3_SR}:       op = ALU_ROR;
                default:               op = ALU_NONE;
            endcase
        end
    end

    always_comb begin
        id_ex.op  = op;
        id_ex.a   = resolve(rs1_addr, rs1_data);
        id_ex.b   = use_imm ? imm_i : resolve(rs2_addr, rs2_data);
        id_ex.rd  = instr[11:7];
        id_ex.wen = (op != ALU_NONE);
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  rv_pkg::id_ex_t id_ex,
    output rv_pkg::ex_wb_t ex_wb
);
    import rv_pkg::*;

    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [4:0]        shamt;
    logic [2*XLEN-1:0] rol_wide;
    logic [2*XLEN-1:0] ror_wide;
    logic [XLEN-1:0]   result;

    assign a     = id_ex.a;
    assign b     = id_ex.b;
    assign shamt = b[4:0];

    // Doubled word makes rotate by zero come out right
    assign rol_wide = {a, a} << shamt;
    assign ror_wide = {a, a} >> shamt;

    always_comb begin
        case (id_ex.op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_ANDN: result = a & ~b;
            ALU_ORN:  result = a | ~b;
            ALU_XNOR: result = ~(a ^ b);
            ALU_MIN:  result = ($signed(a) < $signed(b)) ? a : b;
            ALU_MAX:  result = ($signed(a) > $signed(b)) ? a : b;
            ALU_MINU: result = (a < b) ? a : b;
            ALU_MAXU: result = (a > b) ? a : b;
            ALU_ROL:  result = rol_wide[2*XLEN-1:XLEN]; // upper half
            ALU_ROR:  result = ror_wide[XLEN-1:0];
            default:  result = '0;                      // ALU_NONE
        endcase
    end

    always_comb begin
        ex_wb.rd     = id_ex.rd;
        ex_wb.result = result;
        ex_wb.wen    = id_ex.wen && (id_ex.rd != '0); // x0 never written
    end

endmodule

// ==== hw/rv_alu_pipe.sv ====
`timescale 1ns/1ns

module rv_alu_pipe (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [31:0]                   in_instr,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [rv_pkg::REG_ADDR_W-1:0] out_rd,
    output logic [rv_pkg::XLEN-1:0]       out_data,
    output logic                          out_wen
);
    import rv_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    id_ex_t id_ex_d;    // decode output
    id_ex_t id_ex_q;    // ALU input
    logic   id_ex_valid;
    logic   ex_ready;
    ex_wb_t ex_wb_d;    // ALU output
    ex_wb_t ex_wb_q;
    logic   wb_fire;    // output transfer, also the regfile write

    assign out_rd   = ex_wb_q.rd;
    assign out_data = ex_wb_q.result;
    assign out_wen  = ex_wb_q.wen;
    assign wb_fire  = out_valid && out_ready;

    decode_stage i_decode_stage (
        .instr     (in_instr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .ex_valid  (id_ex_valid),
        .ex_rd     (ex_wb_d.rd),
        .ex_wen    (ex_wb_d.wen),
        .ex_result (ex_wb_d.result),
        .wb_valid  (out_valid),
        .wb_rd     (ex_wb_q.rd),
        .wb_wen    (ex_wb_q.wen),
        .wb_result (ex_wb_q.result),
        .id_ex     (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (id_ex_d),
        .out_valid (id_ex_valid),
        .out_ready (ex_ready),
        .out_data  (id_ex_q)
    );

    alu i_alu (
        .id_ex (id_ex_q),
        .ex_wb (ex_wb_d)
    );

    pipe_reg #(.payload_t(ex_wb_t)) i_ex_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (id_ex_valid),
        .in_ready  (ex_ready),
        .in_data   (ex_wb_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (ex_wb_q)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_fire && ex_wb_q.wen),
        .wr_addr  (ex_wb_q.rd),
        .wr_data  (ex_wb_q.result)
    );

endmodule

// ==== tb/rv_alu_pipe_checker.sv ====
`timescale 1ns/1ns

module rv_alu_pipe_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          out_valid,
    input logic                          out_ready,
    input logic [rv_pkg::REG_ADDR_W-1:0] out_rd,
    input logic                          out_wen,
    input rv_pkg::ex_wb_t                ex_wb
);

    int fail_count = 0; // summed into the testbench result

    // A stalled result must not move
    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(ex_wb))
    else begin
        fail_count++;
        $error("Output changed while out_ready was low");
    end

    empty_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high in the cycle after reset");
    end

    // x0 is never a write target
    no_write_to_x0: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_wen |-> out_rd != '0)
    else begin
        fail_count++;
        $error("out_wen high with out_rd zero");
    end

endmodule

bind rv_alu_pipe rv_alu_pipe_checker i_rv_alu_pipe_checker (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rd    (out_rd),
    .out_wen   (out_wen),
    .ex_wb     (ex_wb_q)
);

// ==== tb/tb_rv_alu_pipe.sv ====
`timescale 1ns/1ns

module tb_rv_alu_pipe;
    import rv_pkg::*;

    localparam int MAX_CASES   = 64;
    localparam int FIXED_CASES = 8; // out_ready held high for these

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [31:0]           in_instr;
    logic                  out_valid;
    logic                  out_ready;
    logic [REG_ADDR_W-1:0] out_rd;
    logic [XLEN-1:0]       out_data;
    logic                  out_wen;

    logic [31:0] cases_mem [0:4*MAX_CASES-1]; // instr, rd, data, wen per case
    int          accept_cycle [0:MAX_CASES-1];
    int          pending [$];                 // case indices in flight
    int          num_cases;
    int          in_count;
    int          out_count;
    int          cycle;
    int          last_out_cycle;
    int          cycle_limit;
    int          value_errors;
    int          other_errors;
    int          assert_errors;
    bit          timed_out;
    logic [31:0] rng_state;

    rv_alu_pipe i_rv_alu_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rd    (out_rd),
        .out_data  (out_data),
        .out_wen   (out_wen)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_output();
        int idx;
        int base;
        if (pending.size() == 0) begin
            $display("Output transfer at %0t ns with no instruction in flight", $time);
            other_errors++;
        end else begin
            idx  = pending.pop_front();
            base = 4 * idx;
            if (out_rd !== cases_mem[base+1][REG_ADDR_W-1:0]) begin
                $display("ERROR at %0t ns: out_rd expected %0h, got %0h",
                         $time, cases_mem[base+1][REG_ADDR_W-1:0], out_rd);
                value_errors++;
            end
            if (out_data !== cases_mem[base+2]) begin
                $display("ERROR at %0t ns: out_data expected %08h, got %08h",
                         $time, cases_mem[base+2], out_data);
                value_errors++;
            end
            if (out_wen !== cases_mem[base+3][0]) begin
                $display("ERROR at %0t ns: out_wen expected %0b, got %0b",
                         $time, cases_mem[base+3][0], out_wen);
                value_errors++;
            end
            // Fixed latency and full throughput while out_ready stays high
            if (idx < FIXED_CASES && cycle != accept_cycle[idx] + 2) begin
                $display("Case %0d left %0d cycles after acceptance instead of 2",
                         idx, cycle - accept_cycle[idx]);
                other_errors++;
            end
            if (idx > 0 && idx < FIXED_CASES && cycle != last_out_cycle + 1) begin
                $display("Case %0d did not leave in the cycle after case %0d", idx, idx - 1);
                other_errors++;
            end
            last_out_cycle = cycle;
            out_count++;
        end
    endtask

    // Drive on the falling edge, sample a quarter period later
    task automatic step_cycle();
        @(negedge clk);
        in_valid  = (in_count < num_cases);
        in_instr  = in_valid ? cases_mem[4*in_count] : 32'h0;
        rng_state = lcg_next(rng_state);
        out_ready = (out_count < FIXED_CASES) ? 1'b1 : rng_state[16];
        #5;
        if (out_valid && out_ready) begin
            check_output();
        end
        if (in_valid && in_ready) begin
            accept_cycle[in_count] = cycle;
            pending.push_back(in_count);
            in_count++;
        end
        cycle++;
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_instr       = 32'h0;
        out_ready      = 1'b0;
        rng_state      = 32'h4fba_2335;
        in_count       = 0;
        out_count      = 0;
        cycle          = 0;
        last_out_cycle = 0;
        value_errors   = 0;
        other_errors   = 0;
        timed_out      = 1'b0;

        $readmemh("tb/alu_cases.txt", cases_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && !$isunknown(cases_mem[4*num_cases])) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No cases were read from tb/alu_cases.txt");
            other_errors++;
        end
        cycle_limit = 8 * num_cases + 100;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #5;
        if (out_valid !== 1'b0) begin
            $display("ERROR at %0t ns: out_valid expected 0, got %0b", $time, out_valid);
            value_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("ERROR at %0t ns: in_ready expected 1, got %0b", $time, in_ready);
            value_errors++;
        end

        while (out_count < num_cases && !timed_out) begin
            step_cycle();
            if (cycle >= cycle_limit) begin
                $display("Timeout after %0d cycles with %0d of %0d results received",
                         cycle, out_count, num_cases);
                timed_out = 1'b1;
                other_errors++;
            end
        end

        // Nothing may come out once every case has retired
        if (!timed_out) begin
            repeat (6) begin
                @(negedge clk);
                in_valid  = 1'b0;
                out_ready = 1'b1;
                #5;
                if (out_valid) begin
                    $display("Extra output at %0t ns after all cases retired", $time);
                    other_errors++;
                end
            end
        end

        assert_errors = i_rv_alu_pipe.i_rv_alu_pipe_checker.fail_count;
        $display("Summary: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_alu_pipe.f ====
hw/rv_pkg.sv
hw/reg_file.sv
hw/pipe_reg.sv
hw/decode_stage.sv
hw/alu.sv
hw/rv_alu_pipe.sv
tb/rv_alu_pipe_checker.sv
tb/tb_rv_alu_pipe.sv

// ==== Bender.yml ====
package:
  name: rv_alu_pipe

sources:
  - hw/rv_pkg.sv
  - hw/reg_file.sv
  - hw/pipe_reg.sv
  - hw/decode_stage.sv
  - hw/alu.sv
  - hw/rv_alu_pipe.sv
  - target: simulation
    files:
      - tb/rv_alu_pipe_checker.sv
      - tb/tb_rv_alu_pipe.sv

// ==== tb/alu_cases.txt ====
// Columns in hex: instruction, expected rd, expected data, expected write flag
// Registers start at zero; the first 8 lines retire with out_ready held high
00028093 01 00000000 1 // addi x1, x5, 0
000F8113 02 00000000 1 // addi x2, x31, 0
00500093 01 00000005 1 // addi x1, x0, 5
FFF00113 02 FFFFFFFF 1 // addi x2, x0, -1
002081B3 03 00000004 1 // add x3, x1, x2
40118233 04 FFFFFFFF 1 // sub x4, x3, x1
7FF00293 05 000007FF 1 // addi x5, x0, 2047
8002C313 06 FFFFFFFF 1 // xori x6, x5, -2048
0F00E393 07 000000F5 1 // ori x7, x1, 0xf0
03C3F413 08 00000034 1 // andi x8, x7, 0x3c
007094B3 09 00A00000 1 // sll x9, x1, x7
00115533 0A 07FFFFFF 1 // srl x10, x2, x1
F0000613 0C FFFFFF00 1 // addi x12, x0, -256
403656B3 0D FFFFFFF0 1 // sra x13, x12, x3
01F00793 0F 0000001F 1 // addi x15, x0, 31
12300813 10 00000123 1 // addi x16, x0, 0x123
60F818B3 11 80000091 1 // rol x17, x16, x15
60F85933 12 00000246 1 // ror x18, x16, x15
600819B3 13 00000123 1 // rol x19, x16, x0
60085A33 14 00000123 1 // ror x20, x16, x0
00100A93 15 00000001 1 // addi x21, x0, 1
00FA9B33 16 80000000 1 // sll x22, x21, x15
0A2B4BB3 17 80000000 1 // min x23, x22, x2
0A2B5C33 18 80000000 1 // minu x24, x22, x2
0A1B6CB3 19 00000005 1 // max x25, x22, x1
0A1B7D33 1A 80000000 1 // maxu x26, x22, x1
0A20CDB3 1B FFFFFFFF 1 // min x27, x1, x2
40717EB3 1D FFFFFF0A 1 // andn x29, x2, x7
4020EF33 1E 00000005 1 // orn x30, x1, x2
4070CFB3 1F FFFFFF0F 1 // xnor x31, x1, x7
0070E1B3 03 000000F5 1 // or x3, x1, x7
0020C233 04 FFFFFFFA 1 // xor x4, x1, x2
0041F2B3 05 000000F0 1 // and x5, x3, x4
00508013 00 0000000A 0 // addi x0, x1, 5
00000333 06 00000000 1 // add x6, x0, x0
0010A393 07 00000000 0 // slti x7, x1, 1 is not supported
02108433 08 00000000 0 // mul x8, x1, x1 is not supported
00040493 09 00000034 1 // addi x9, x8, 0
